// ==== build.f ====
+incdir+src
+incdir+testbench
src/rv32_pkg.sv
src/rv32_imm_gen.sv
src/rv32_instr_decoder.sv
src/rv32_regfile.sv
src/rv32_decode_stage.sv
testbench/tb_rv32_decode.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f build.f --top-module tb_rv32_decode -o tb_rv32_decode

./obj_dir/tb_rv32_decode > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
    echo "Simulation PASSED"
    exit 0
fi
echo "Simulation FAILED"
exit 1

// ==== src/rv32_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_decode_stage (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  stall_i,
    input  logic                  flush_i,
    input  logic [`RV32_XLEN-1:0] pc_i,
    input  logic [`RV32_XLEN-1:0] instr_i,
    input  rv32_pkg::wb_t         wb_i,
    output rv32_pkg::ctrl_t       ctrl_o,
    output rv32_pkg::data_t       data_o
);

    rv32_pkg::ctrl_t       dec_ctrl;
    rv32_pkg::ctrl_t       cap_ctrl;
    rv32_pkg::ctrl_t       ctrl_q;
    rv32_pkg::imm_fmt_e    imm_fmt;
    logic [`RV32_XLEN-1:0] imm;
    logic [`RV32_XLEN-1:0] pc_q;
    logic [`RV32_XLEN-1:0] imm_q;
    logic [`RV32_XLEN-1:0] rs1_value;
    logic [`RV32_XLEN-1:0] rs2_value;

    rv32_instr_decoder u_decoder (
        .instr_i   (instr_i),
        .ctrl_o    (dec_ctrl),
        .imm_fmt_o (imm_fmt)
    );

    rv32_imm_gen u_imm_gen (
        .instr_i (instr_i),
        .fmt_i   (imm_fmt),
        .imm_o   (imm)
    );

    // Read data is registered inside the file, in step with ctrl_q
    rv32_regfile u_regfile (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .stall_i     (stall_i),
        .rs1_i       (dec_ctrl.rs1),
        .rs2_i       (dec_ctrl.rs2),
        .wb_i        (wb_i),
        .rs1_value_o (rs1_value),
        .rs2_value_o (rs2_value)
    );

    // Flushed instruction keeps flowing but loses its side effects
    always_comb begin
        cap_ctrl = dec_ctrl;
        if (flush_i) begin
            cap_ctrl.mem_read  = 1'b0;
            cap_ctrl.mem_write = 1'b0;
            cap_ctrl.rd_write  = 1'b0;
            cap_ctrl.branch_op = rv32_pkg::BR_NEVER;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q <= '0;
            pc_q   <= '0;
            imm_q  <= '0;
        end else if (!stall_i) begin
            ctrl_q <= cap_ctrl;
            pc_q   <= pc_i;
            imm_q  <= imm;
        end
    end

    assign ctrl_o = ctrl_q;
    assign data_o = '{pc: pc_q, rs1_value: rs1_value, rs2_value: rs2_value, imm: imm_q};

endmodule

`default_nettype wire

// ==== src/rv32_defines.svh ====
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// Datapath and register file sizes
`define RV32_XLEN        32
`define RV32_REG_ADDR_W  5
`define RV32_NUM_REGS    32

// Major opcodes, instr[6:0]
`define RV32_OPC_LUI      7'b0110111
`define RV32_OPC_AUIPC    7'b0010111
`define RV32_OPC_JAL      7'b1101111
`define RV32_OPC_JALR     7'b1100111
`define RV32_OPC_BRANCH   7'b1100011
`define RV32_OPC_LOAD     7'b0000011
`define RV32_OPC_STORE    7'b0100011
`define RV32_OPC_OP_IMM   7'b0010011
`define RV32_OPC_OP       7'b0110011
`define RV32_OPC_MISC_MEM 7'b0001111

// funct7 values
`define RV32_F7_BASE 7'b0000000
`define RV32_F7_ALT  7'b0100000

// funct3 values shared by OP and OP-IMM
`define RV32_F3_ADD  3'b000
`define RV32_F3_SLL  3'b001
`define RV32_F3_SLT  3'b010
`define RV32_F3_SLTU 3'b011
`define RV32_F3_XOR  3'b100
`define RV32_F3_SRL  3'b101
`define RV32_F3_OR   3'b110
`define RV32_F3_AND  3'b111

// MISC-MEM
`define RV32_F3_FENCE   3'b000
`define RV32_F3_FENCE_I 3'b001

`endif

// ==== src/rv32_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_imm_gen (
    input  logic [`RV32_XLEN-1:0] instr_i,
    input  rv32_pkg::imm_fmt_e    fmt_i,
    output logic [`RV32_XLEN-1:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (fmt_i)
            rv32_pkg::IMM_I: begin
                imm_o = {{21{sign}}, instr_i[30:20]};
            end
            rv32_pkg::IMM_S: begin
                imm_o = {{21{sign}}, instr_i[30:25], instr_i[11:7]};
            end
            rv32_pkg::IMM_B: begin
                imm_o = {{20{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
            end
            rv32_pkg::IMM_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            rv32_pkg::IMM_J: begin
                imm_o = {{12{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
            end
            // Shift amount sits in the rs2 field
            rv32_pkg::IMM_SHAMT: begin
                imm_o = {27'b0, instr_i[24:20]};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/rv32_instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_instr_decoder (
    input  logic [`RV32_XLEN-1:0] instr_i,
    output rv32_pkg::ctrl_t       ctrl_o,
    output rv32_pkg::imm_fmt_e    imm_fmt_o
);

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic               match;
    rv32_pkg::ctrl_t    dec;
    rv32_pkg::imm_fmt_e fmt;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    // ALU operation shared by OP and OP-IMM
    function automatic rv32_pkg::alu_op_e alu_op_of(input logic [2:0] f3);
        alu_op_of = rv32_pkg::ALU_NONE;
        case (f3)
            `RV32_F3_ADD:  alu_op_of = rv32_pkg::ALU_ADD_SUB;
            `RV32_F3_SLL:  alu_op_of = rv32_pkg::ALU_SLL;
            `RV32_F3_SLT:  alu_op_of = rv32_pkg::ALU_SLT;
            `RV32_F3_SLTU: alu_op_of = rv32_pkg::ALU_SLTU;
            `RV32_F3_XOR:  alu_op_of = rv32_pkg::ALU_XOR;
            `RV32_F3_SRL:  alu_op_of = rv32_pkg::ALU_SRL_SRA;
            `RV32_F3_OR:   alu_op_of = rv32_pkg::ALU_OR;
            `RV32_F3_AND:  alu_op_of = rv32_pkg::ALU_AND;
            default:       alu_op_of = rv32_pkg::ALU_NONE;
        endcase
    endfunction

    always_comb begin
        dec   = '0;
        fmt   = rv32_pkg::IMM_NONE;
        match = 1'b0;

        case (opcode)
            `RV32_OPC_LUI: begin
                match        = 1'b1;
                dec.alu_op   = rv32_pkg::ALU_SRC2;
                dec.alu_src2 = rv32_pkg::SRC2_IMM;
                dec.rd_write = 1'b1;
                fmt          = rv32_pkg::IMM_U;
            end
            `RV32_OPC_AUIPC: begin
                match        = 1'b1;
                dec.alu_op   = rv32_pkg::ALU_ADD_SUB;
                dec.alu_src1 = rv32_pkg::SRC1_PC;
                dec.alu_src2 = rv32_pkg::SRC2_IMM;
                dec.rd_write = 1'b1;
                fmt          = rv32_pkg::IMM_U;
            end
            // Link value is pc + 4, target comes from the branch unit
            `RV32_OPC_JAL: begin
                match             = 1'b1;
                dec.alu_op        = rv32_pkg::ALU_SRC1P4;
                dec.alu_src1      = rv32_pkg::SRC1_PC;
                dec.branch_op     = rv32_pkg::BR_ALWAYS;
                dec.branch_pc_src = rv32_pkg::BR_PC_IMM;
                dec.rd_write      = 1'b1;
                fmt               = rv32_pkg::IMM_J;
            end
            `RV32_OPC_JALR: begin
                match             = (funct3 == 3'b000);
                dec.alu_op        = rv32_pkg::ALU_SRC1P4;
                dec.alu_src1      = rv32_pkg::SRC1_PC;
                dec.branch_op     = rv32_pkg::BR_ALWAYS;
                dec.branch_pc_src = rv32_pkg::BR_PC_REG;
                dec.rd_write      = 1'b1;
                fmt               = rv32_pkg::IMM_I;
            end
            // funct3[2] picks a compare, funct3[1] unsigned, funct3[0] inverts
            `RV32_OPC_BRANCH: begin
                match           = (funct3[2:1] != 2'b01);
                dec.alu_sub_sra = 1'b1;
                if (!funct3[2]) begin
                    dec.alu_op = rv32_pkg::ALU_ADD_SUB;
                end else if (funct3[1]) begin
                    dec.alu_op = rv32_pkg::ALU_SLTU;
                end else begin
                    dec.alu_op = rv32_pkg::ALU_SLT;
                end
                dec.branch_op = (funct3[2] ^ funct3[0]) ? rv32_pkg::BR_NON_ZERO
                                                        : rv32_pkg::BR_ZERO;
                dec.branch_pc_src = rv32_pkg::BR_PC_IMM;
                fmt               = rv32_pkg::IMM_B;
            end
            `RV32_OPC_LOAD: begin
                match               = (funct3[1:0] != 2'b11) && (funct3 != 3'b110);
                dec.alu_op          = rv32_pkg::ALU_ADD_SUB;
                dec.alu_src2        = rv32_pkg::SRC2_IMM;
                dec.mem_read        = 1'b1;
                dec.mem_width       = rv32_pkg::mem_width_e'(funct3[1:0]);
                dec.mem_zero_extend = funct3[2];
                dec.rd_write        = 1'b1;
                fmt                 = rv32_pkg::IMM_I;
            end
            `RV32_OPC_STORE: begin
                match         = !funct3[2] && (funct3[1:0] != 2'b11);
                dec.alu_op    = rv32_pkg::ALU_ADD_SUB;
                dec.alu_src2  = rv32_pkg::SRC2_IMM;
                dec.mem_write = 1'b1;
                dec.mem_width = rv32_pkg::mem_width_e'(funct3[1:0]);
                fmt           = rv32_pkg::IMM_S;
            end
            `RV32_OPC_OP_IMM: begin
                dec.alu_op   = alu_op_of(funct3);
                dec.alu_src2 = rv32_pkg::SRC2_IMM;
                dec.rd_write = 1'b1;
                case (funct3)
                    `RV32_F3_SLL: begin
                        match = (funct7 == `RV32_F7_BASE);
                        fmt   = rv32_pkg::IMM_SHAMT;
                    end
                    `RV32_F3_SRL: begin
                        match           = (funct7 == `RV32_F7_BASE)
                                       || (funct7 == `RV32_F7_ALT);
                        dec.alu_sub_sra = funct7[5];
                        fmt             = rv32_pkg::IMM_SHAMT;
                    end
                    default: begin
                        match           = 1'b1;
                        dec.alu_sub_sra = (funct3 == `RV32_F3_SLT)
                                       || (funct3 == `RV32_F3_SLTU);
                        fmt             = rv32_pkg::IMM_I;
                    end
                endcase
            end
            // Only ADD and SRL have an alternate form (SUB, SRA)
            `RV32_OPC_OP: begin
                match = (funct7 == `RV32_F7_BASE)
                     || ((funct7 == `RV32_F7_ALT)
                         && ((funct3 == `RV32_F3_ADD) || (funct3 == `RV32_F3_SRL)));
                dec.alu_op      = alu_op_of(funct3);
                dec.alu_sub_sra = funct7[5]
                               || (funct3 == `RV32_F3_SLT)
                               || (funct3 == `RV32_F3_SLTU);
                dec.rd_write    = 1'b1;
            end
            // FENCE and FENCE.I retire without side effects
            `RV32_OPC_MISC_MEM: begin
                match = (funct3 == `RV32_F3_FENCE) || (funct3 == `RV32_F3_FENCE_I);
            end
            default: begin
                match = 1'b0;
            end
        endcase

        if (!match) begin
            dec = '0;
            fmt = rv32_pkg::IMM_NONE;
        end
        dec.valid = match;

        // Register fields pass through whatever the opcode
        dec.rd  = instr_i[11:7];
        dec.rs1 = instr_i[19:15];
        dec.rs2 = instr_i[24:20];
    end

    assign ctrl_o    = dec;
    assign imm_fmt_o = fmt;

endmodule

`default_nettype wire

// ==== src/rv32_pkg.sv ====
`default_nettype none

`include "rv32_defines.svh"

package rv32_pkg;

    typedef enum logic [3:0] {
        ALU_NONE    = 4'd0,
        ALU_ADD_SUB = 4'd1,
        ALU_XOR     = 4'd2,
        ALU_OR      = 4'd3,
        ALU_AND     = 4'd4,
        ALU_SLL     = 4'd5,
        ALU_SRL_SRA = 4'd6,
        ALU_SLT     = 4'd7,
        ALU_SLTU    = 4'd8,
        ALU_SRC1P4  = 4'd9,
        ALU_SRC2    = 4'd10
    } alu_op_e;

    typedef enum logic {
        SRC1_REG = 1'b0,
        SRC1_PC  = 1'b1
    } alu_src1_e;

    typedef enum logic {
        SRC2_REG = 1'b0,
        SRC2_IMM = 1'b1
    } alu_src2_e;

    // Encoding matches funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_BYTE = 2'd0,
        MEM_HALF = 2'd1,
        MEM_WORD = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        BR_NEVER    = 2'd0,
        BR_ZERO     = 2'd1,
        BR_NON_ZERO = 2'd2,
        BR_ALWAYS   = 2'd3
    } branch_op_e;

    typedef enum logic {
        BR_PC_IMM = 1'b0,
        BR_PC_REG = 1'b1
    } branch_pc_src_e;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_B     = 3'd3,
        IMM_U     = 3'd4,
        IMM_J     = 3'd5,
        IMM_SHAMT = 3'd6
    } imm_fmt_e;

    typedef struct packed {
        logic                         valid;
        alu_op_e                      alu_op;
        logic                         alu_sub_sra;
        alu_src1_e                    alu_src1;
        alu_src2_e                    alu_src2;
        logic                         mem_read;
        logic                         mem_write;
        mem_width_e                   mem_width;
        logic                         mem_zero_extend;
        branch_op_e                   branch_op;
        branch_pc_src_e               branch_pc_src;
        logic                         rd_write;
        logic [`RV32_REG_ADDR_W-1:0]  rd;
        logic [`RV32_REG_ADDR_W-1:0]  rs1;
        logic [`RV32_REG_ADDR_W-1:0]  rs2;
    } ctrl_t;

    typedef struct packed {
        logic [`RV32_XLEN-1:0] pc;
        logic [`RV32_XLEN-1:0] rs1_value;
        logic [`RV32_XLEN-1:0] rs2_value;
        logic [`RV32_XLEN-1:0] imm;
    } data_t;

    typedef struct packed {
        logic                        write;
        logic [`RV32_REG_ADDR_W-1:0] rd;
        logic [`RV32_XLEN-1:0]       value;
    } wb_t;

endpackage

`default_nettype wire

// ==== src/rv32_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module rv32_regfile (
    input  logic                        clk,
    input  logic                        arst_n_i,
    input  logic                        stall_i,
    input  logic [`RV32_REG_ADDR_W-1:0] rs1_i,
    input  logic [`RV32_REG_ADDR_W-1:0] rs2_i,
    input  rv32_pkg::wb_t               wb_i,
    output logic [`RV32_XLEN-1:0]       rs1_value_o,
    output logic [`RV32_XLEN-1:0]       rs2_value_o
);

    // x0 has no storage
    logic [`RV32_XLEN-1:0] regs [1:`RV32_NUM_REGS-1];

    // Same-cycle writeback wins over the stored value
    function automatic logic [`RV32_XLEN-1:0] read_port(
        input logic [`RV32_REG_ADDR_W-1:0] addr
    );
        if (addr == '0) begin
            read_port = '0;
        end else if (wb_i.write && (wb_i.rd == addr)) begin
            read_port = wb_i.value;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    // Writeback goes ahead during a stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < `RV32_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_i.write && (wb_i.rd != '0)) begin
            regs[wb_i.rd] <= wb_i.value;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rs1_value_o <= '0;
            rs2_value_o <= '0;
        end else if (!stall_i) begin
            rs1_value_o <= read_port(rs1_i);
            rs2_value_o <= read_port(rs2_i);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rv32_decode_ref.svh ====
// LCG state, one sequence per run
logic [31:0] lcg_state = 32'd25;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
endfunction

// OP and OP-IMM operation by funct3
function automatic rv32_pkg::alu_op_e ref_alu(input logic [2:0] f3);
    case (f3)
        3'd0: return rv32_pkg::ALU_ADD_SUB;
        3'd1: return rv32_pkg::ALU_SLL;
        3'd2: return rv32_pkg::ALU_SLT;
        3'd3: return rv32_pkg::ALU_SLTU;
        3'd4: return rv32_pkg::ALU_XOR;
        3'd5: return rv32_pkg::ALU_SRL_SRA;
        3'd6: return rv32_pkg::ALU_OR;
        default: return rv32_pkg::ALU_AND;
    endcase
endfunction

function automatic rv32_pkg::ctrl_t ref_decode(input logic [31:0] i, output logic [31:0] imm);
    rv32_pkg::ctrl_t c;
    logic [2:0]      f3;
    logic [6:0]      f7;
    c   = '0;
    imm = '0;
    f3  = i[14:12];
    f7  = i[31:25];
    case (i[6:0])
        `RV32_OPC_LUI, `RV32_OPC_AUIPC: begin
            c.valid    = 1'b1;
            c.alu_op   = (i[5]) ? rv32_pkg::ALU_SRC2 : rv32_pkg::ALU_ADD_SUB;
            c.alu_src1 = (i[5]) ? rv32_pkg::SRC1_REG : rv32_pkg::SRC1_PC;
            c.alu_src2 = rv32_pkg::SRC2_IMM;
            c.rd_write = 1'b1;
            imm        = {i[31:12], 12'h000};
        end
        `RV32_OPC_JAL: begin
            c.valid     = 1'b1;
            c.alu_op    = rv32_pkg::ALU_SRC1P4;
            c.alu_src1  = rv32_pkg::SRC1_PC;
            c.branch_op = rv32_pkg::BR_ALWAYS;
            c.rd_write  = 1'b1;
            imm = {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
        end
        `RV32_OPC_JALR: if (f3 == 3'b000) begin
            c.valid         = 1'b1;
            c.alu_op        = rv32_pkg::ALU_SRC1P4;
            c.alu_src1      = rv32_pkg::SRC1_PC;
            c.branch_op     = rv32_pkg::BR_ALWAYS;
            c.branch_pc_src = rv32_pkg::BR_PC_REG;
            c.rd_write      = 1'b1;
            imm             = {{20{i[31]}}, i[31:20]};
        end
        // BEQ and BGE(U) take the branch on a zero compare result
        `RV32_OPC_BRANCH: if (f3 != 3'b010 && f3 != 3'b011) begin
            c.valid       = 1'b1;
            c.alu_sub_sra = 1'b1;
            if (f3 == 3'b000 || f3 == 3'b001) begin
                c.alu_op = rv32_pkg::ALU_ADD_SUB;
            end else if (f3 == 3'b100 || f3 == 3'b101) begin
                c.alu_op = rv32_pkg::ALU_SLT;
            end else begin
                c.alu_op = rv32_pkg::ALU_SLTU;
            end
            c.branch_op = (f3 == 3'b000 || f3 == 3'b101 || f3 == 3'b111)
                        ? rv32_pkg::BR_ZERO : rv32_pkg::BR_NON_ZERO;
            imm = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
        end
        `RV32_OPC_LOAD: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
            c.valid           = 1'b1;
            c.alu_op          = rv32_pkg::ALU_ADD_SUB;
            c.alu_src2        = rv32_pkg::SRC2_IMM;
            c.mem_read        = 1'b1;
            c.mem_width       = rv32_pkg::mem_width_e'(f3[1:0]);
            c.mem_zero_extend = f3[2];
            c.rd_write        = 1'b1;
            imm               = {{20{i[31]}}, i[31:20]};
        end
        `RV32_OPC_STORE: if (f3 inside {3'd0, 3'd1, 3'd2}) begin
            c.valid     = 1'b1;
            c.alu_op    = rv32_pkg::ALU_ADD_SUB;
            c.alu_src2  = rv32_pkg::SRC2_IMM;
            c.mem_write = 1'b1;
            c.mem_width = rv32_pkg::mem_width_e'(f3[1:0]);
            imm         = {{20{i[31]}}, i[31:25], i[11:7]};
        end
        `RV32_OPC_OP_IMM: begin
            if (f3 == 3'b001) begin
                c.valid = (f7 == 7'h00);
            end else if (f3 == 3'b101) begin
                c.valid = (f7 == 7'h00) || (f7 == 7'h20);
            end else begin
                c.valid = 1'b1;
            end
            if (c.valid) begin
                c.alu_op      = ref_alu(f3);
                c.alu_sub_sra = (f3 == 3'b101) ? f7[5] : (f3 == 3'b010 || f3 == 3'b011);
                c.alu_src2    = rv32_pkg::SRC2_IMM;
                c.rd_write    = 1'b1;
                imm = (f3[1:0] == 2'b01) ? {27'd0, i[24:20]} : {{20{i[31]}}, i[31:20]};
            end
        end
        `RV32_OPC_OP: if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
            c.valid       = 1'b1;
            c.alu_op      = ref_alu(f3);
            c.alu_sub_sra = f7[5] || f3 == 3'b010 || f3 == 3'b011;
            c.rd_write    = 1'b1;
        end
        `RV32_OPC_MISC_MEM: c.valid = (f3 == 3'b000 || f3 == 3'b001);
        default: c.valid = 1'b0;
    endcase
    c.rd  = i[11:7];
    c.rs1 = i[19:15];
    c.rs2 = i[24:20];
    return c;
endfunction

task automatic check_ctrl(input string name, input rv32_pkg::ctrl_t exp,
                          input rv32_pkg::ctrl_t act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("** Error: %s ctrl_o expected %h actual %h", name, exp, act);
    end
endtask

task automatic check_data(input string name, input rv32_pkg::data_t exp,
                          input rv32_pkg::data_t act);
    check_count++;
    if (act !== exp) begin
        err_count++;
        $display("** Error: %s data_o expected %h actual %h", name, exp, act);
    end
endtask

// ==== testbench/tb_rv32_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv32_defines.svh"

module tb_rv32_decode;

    localparam int TIMEOUT_CYCLES = 20;
    // ECALL, EBREAK, CSRRW, CSRRS, all-ones, MUL, FENCE, FENCE.I
    localparam logic [31:0] ODD_WORDS [0:7] = '{
        32'h00000073, 32'h00100073, 32'h34011073, 32'h30002573,
        32'hffffffff, 32'h02208033, 32'h0ff0000f, 32'h0000100f
    };

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  stall;
    logic                  flush;
    logic [`RV32_XLEN-1:0] pc;
    logic [`RV32_XLEN-1:0] instr;
    rv32_pkg::wb_t         wb;
    rv32_pkg::ctrl_t       ctrl;
    rv32_pkg::data_t       data;

    logic [`RV32_XLEN-1:0] shadow [0:`RV32_NUM_REGS-1];
    string                 chk_name;
    rv32_pkg::ctrl_t       exp_ctrl;
    rv32_pkg::data_t       exp_data;
    int                    chk_seq = 0;
    int                    chk_ack = 0;
    int                    check_count = 0;
    int                    err_count = 0;
    int                    tests_passed = 0;
    int                    tests_failed = 0;
    int                    err_base = 0;
    int                    chk_base = 0;
    logic                  timed_out = 1'b0;

    `include "rv32_decode_ref.svh"

    rv32_decode_stage uut (
        .clk      (clk),
        .arst_n_i (arst_n),
        .stall_i  (stall),
        .flush_i  (flush),
        .pc_i     (pc),
        .instr_i  (instr),
        .wb_i     (wb),
        .ctrl_o   (ctrl),
        .data_o   (data)
    );

    always #50 clk = ~clk;

    // Compare half a cycle after the capture edge
    always @(negedge clk) begin
        if (chk_ack != chk_seq) begin
            check_ctrl(chk_name, exp_ctrl, ctrl);
            check_data(chk_name, exp_data, data);
            chk_ack = chk_seq;
        end
    end

    // Random word of one instruction class, fields kept legal
    function automatic logic [31:0] make_instr(input int cls);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r  = lcg_next();
        f3 = r[14:12];
        f7 = 7'b0;
        case (cls % 10)
            0: return {r[31:7], `RV32_OPC_LUI};
            1: return {r[31:7], `RV32_OPC_AUIPC};
            2: return {r[31:7], `RV32_OPC_JAL};
            3: return {r[31:15], 3'b000, r[11:7], `RV32_OPC_JALR};
            4: begin
                if (f3[2:1] == 2'b01) f3[2] = 1'b1;
                return {r[31:15], f3, r[11:7], `RV32_OPC_BRANCH};
            end
            5: begin
                if (f3[1:0] == 2'b11) f3[1:0] = 2'b10;
                if (f3 == 3'b110) f3 = 3'b100;
                return {r[31:15], f3, r[11:7], `RV32_OPC_LOAD};
            end
            6: begin
                f3[2] = 1'b0;
                if (f3[1:0] == 2'b11) f3[1:0] = 2'b00;
                return {r[31:15], f3, r[11:7], `RV32_OPC_STORE};
            end
            7: begin
                if (f3 == 3'b101) f7 = r[30] ? `RV32_F7_ALT : 7'b0;
                else if (f3 != 3'b001) f7 = r[31:25];
                return {f7, r[24:15], f3, r[11:7], `RV32_OPC_OP_IMM};
            end
            8: begin
                f7 = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? `RV32_F7_ALT : 7'b0;
                return {f7, r[24:15], f3, r[11:7], `RV32_OPC_OP};
            end
            default: return {r[31:15], 2'b00, r[12], r[11:7], `RV32_OPC_MISC_MEM};
        endcase
    endfunction

    task automatic wait_check();
        int n;
        n = 0;
        while (chk_ack != chk_seq && n < TIMEOUT_CYCLES) begin
            @(posedge clk);
            n++;
        end
        if (chk_ack != chk_seq) begin
            $display("Timeout: no compare for %s after %0d cycles", chk_name, n);
            timed_out = 1'b1;
        end
    endtask

    // Drive one instruction, let it be captured, then have it compared
    task automatic issue(input string name, input logic [31:0] at_pc, input logic [31:0] word,
                         input logic do_flush, input rv32_pkg::wb_t w);
        rv32_pkg::ctrl_t ec;
        logic [31:0]     eimm;
        if (timed_out) return;
        stall <= 1'b0;
        flush <= do_flush;
        pc    <= at_pc;
        instr <= word;
        wb    <= w;
        // Forwarded write is seen by the read in the same cycle
        if (w.write && w.rd != '0) shadow[w.rd] = w.value;
        ec = ref_decode(word, eimm);
        if (do_flush) begin
            ec.mem_read  = 1'b0;
            ec.mem_write = 1'b0;
            ec.rd_write  = 1'b0;
            ec.branch_op = rv32_pkg::BR_NEVER;
        end
        @(posedge clk);
        wb <= '0;
        exp_ctrl           = ec;
        exp_data.pc        = at_pc;
        exp_data.rs1_value = shadow[ec.rs1];
        exp_data.rs2_value = shadow[ec.rs2];
        exp_data.imm       = eimm;
        chk_name           = name;
        chk_seq++;
        wait_check();
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = err_count - err_base;
        if (errs == 0) tests_passed++;
        else tests_failed++;
        $display("%s: %0d checks, %0d errors", name, check_count - chk_base, errs);
        err_base = err_count;
        chk_base = check_count;
    endtask

    initial begin
        logic [31:0]   r;
        logic [4:0]    prev;
        rv32_pkg::wb_t w;
        arst_n = 1'b0;
        stall  = 1'b0;
        flush  = 1'b0;
        pc     = 32'h0000_0400;
        // lw x1, 4(x2) held through reset so a missing clear shows up
        instr  = 32'h00412083;
        wb     = '0;
        for (int k = 0; k < `RV32_NUM_REGS; k++) shadow[k] = '0;
        for (int n = 0; n < 16; n++) @(posedge clk);
        arst_n <= 1'b1;

        exp_ctrl = '0;
        exp_data = '0;
        chk_name = "reset";
        chk_seq++;
        wait_check();
        end_test("reset");

        // rs1 reads the previous target, rs2 the one written this cycle
        prev = 5'd0;
        for (int k = 0; k < 12; k++) begin
            r       = lcg_next();
            w.write = 1'b1;
            w.rd    = (k == 0) ? 5'd0 : r[4:0];
            w.value = lcg_next();
            issue("writeback", {r[31:2], 2'b00},
                  {7'b0, w.rd, prev, 3'b000, r[11:7], `RV32_OPC_OP}, 1'b0, w);
            prev = w.rd;
        end
        end_test("writeback");

        for (int k = 0; k < 60; k++) begin
            r = lcg_next();
            issue("random", {r[31:2], 2'b00}, make_instr(k), 1'b0, '0);
        end
        end_test("random");

        issue("stall", 32'h0000_0100, make_instr(8), 1'b0, '0);
        for (int k = 0; k < 4; k++) begin
            if (!timed_out) begin
                stall <= 1'b1;
                pc    <= lcg_next();
                instr <= lcg_next();
                @(posedge clk);
                chk_name = "stall";
                chk_seq++;
                wait_check();
            end
        end
        issue("stall", 32'h0000_0200, make_instr(5), 1'b0, '0);
        end_test("stall");

        for (int k = 0; k < 16; k++) begin
            r = lcg_next();
            case (k % 4)
                0: issue("flush", {r[31:2], 2'b00}, make_instr(5), 1'b1, '0);
                1: issue("flush", {r[31:2], 2'b00}, make_instr(6), 1'b1, '0);
                2: issue("flush", {r[31:2], 2'b00}, make_instr(4), 1'b1, '0);
                default: issue("flush", {r[31:2], 2'b00}, make_instr(2), 1'b1, '0);
            endcase
        end
        end_test("flush");

        for (int k = 0; k < 8; k++) begin
            issue("illegal", 32'h0000_1000 + 32'(k * 4), ODD_WORDS[k], 1'b0, '0);
        end
        end_test("illegal");

        $display("Tests passed: %0d, failed: %0d (%0d checks, %0d errors)",
                 tests_passed, tests_failed, check_count, err_count);
        if (!timed_out && tests_failed == 0 && err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            if (timed_out) $display("Run stopped early on a timeout");
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
